// File: cce.f
source/cce_pkg.sv
source/cce_inst_ram.sv
source/cce_inst_decode.sv
source/cce_execute.sv
source/cce_pending.sv
source/cce_msg.sv
source/cce.sv
tests/cce_checker.sv
tests/cce_tb.sv

// File: Makefile
# Verilator build and run of the CCE testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= cce_tb
FILELIST  ?= cce.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Everything OK

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

# The run passes only if the pass message shows up in its output
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: tests/cce_tb.sv
// CCE testbench with microcode load and readback, random LCE traffic and ready drops

`timescale 1ns/1ps

module cce_tb import cce_pkg::*; ();

  localparam int num_reqs       = 60;
  localparam int timeout_cycles = 200 * num_reqs + 500;
  // Branch targets whose low three bits double as the flag mask
  localparam int wr_target      = 17;
  localparam int pend_target    = 20;
  localparam int rel_target     = 26;

  logic                    clk;
  logic                    rst;
  logic                    cfg_w_v;
  logic                    cfg_r_v;
  logic                    cfg_run;
  logic [pc_width-1:0]     cfg_addr;
  logic [inst_width-1:0]   cfg_data;
  logic [inst_width-1:0]   ucode_data;
  logic                    req_v;
  logic [lce_id_width-1:0] req_lce;
  logic [paddr_width-1:0]  req_addr;
  lce_req_type_e           req_type;
  logic                    req_yumi;
  logic                    cmd_v;
  logic [lce_id_width-1:0] cmd_lce;
  logic [paddr_width-1:0]  cmd_addr;
  lce_cmd_type_e           cmd_type;
  logic [gpr_width-1:0]    cmd_data;
  logic                    cmd_ready;
  logic                    done;
  int                      error_count;
  int                      cmd_count;
  int                      cycle_count = 0;
  integer                  seed;
  logic [inst_width-1:0]   prog [ucode_depth];

  cce u_cce (
    .clk_i(clk), .rst_i(rst),
    .cfg_w_v_i(cfg_w_v), .cfg_r_v_i(cfg_r_v), .cfg_run_i(cfg_run),
    .cfg_addr_i(cfg_addr), .cfg_data_i(cfg_data), .cfg_ucode_data_o(ucode_data),
    .lce_req_v_i(req_v), .lce_req_lce_i(req_lce), .lce_req_addr_i(req_addr),
    .lce_req_type_i(req_type), .lce_req_yumi_o(req_yumi),
    .lce_cmd_v_o(cmd_v), .lce_cmd_lce_o(cmd_lce), .lce_cmd_addr_o(cmd_addr),
    .lce_cmd_type_o(cmd_type), .lce_cmd_data_o(cmd_data), .lce_cmd_ready_i(cmd_ready)
  );

  cce_checker u_checker (
    .clk_i(clk), .rst_i(rst),
    .cfg_w_v_i(cfg_w_v), .cfg_r_v_i(cfg_r_v), .cfg_run_i(cfg_run),
    .cfg_addr_i(cfg_addr), .cfg_data_i(cfg_data), .cfg_ucode_data_i(ucode_data),
    .lce_req_v_i(req_v), .lce_req_lce_i(req_lce), .lce_req_addr_i(req_addr),
    .lce_req_type_i(req_type), .lce_req_yumi_i(req_yumi),
    .lce_cmd_v_i(cmd_v), .lce_cmd_lce_i(cmd_lce), .lce_cmd_addr_i(cmd_addr),
    .lce_cmd_type_i(cmd_type), .lce_cmd_data_i(cmd_data), .lce_cmd_ready_i(cmd_ready),
    .done_i(done), .error_count_o(error_count), .cmd_count_o(cmd_count)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
  end

  ////////////////////////////////////////
  // Microcode
  ////////////////////////////////////////

  function automatic logic [inst_width-1:0] encode_inst(
    input cce_opcode_e op, input int dst, input int src_a, input int imm
  );
    return {op, 2'(dst), 2'(src_a), 2'd0, 5'd0, 16'(imm)};
  endfunction

  // r0 counts grants and the loop runs once per request
  task automatic build_program();
    for (int a = 0; a < ucode_depth; a++) begin
      // Unused words are nops tagged with their address
      prog[a] = {e_op_nop, 11'd0, 10'h15a, 6'(a)};
    end
    prog[0] = encode_inst(e_op_poph, 0, 0, 0);
    prog[1] = encode_inst(e_op_rdp, 0, 0, 0);
    prog[2] = encode_inst(e_op_bfand, 0, 0, rel_target);
    prog[3] = encode_inst(e_op_bfand, 0, 0, pend_target);
    prog[4] = encode_inst(e_op_addi, 0, 0, 1);
    prog[5] = encode_inst(e_op_bfand, 0, 0, wr_target);
    prog[6] = encode_inst(e_op_send, 0, 0, int'(e_cmd_grant_s));
    prog[7] = encode_inst(e_op_bi, 0, 0, 0);
    prog[wr_target]     = encode_inst(e_op_wdp, 0, 0, 1);
    prog[wr_target+1]   = encode_inst(e_op_send, 0, 0, int'(e_cmd_grant_e));
    prog[wr_target+2]   = encode_inst(e_op_bi, 0, 0, 0);
    prog[pend_target]   = encode_inst(e_op_send, 0, 0, int'(e_cmd_retry));
    prog[pend_target+1] = encode_inst(e_op_bi, 0, 0, 0);
    prog[rel_target]    = encode_inst(e_op_wdp, 0, 0, 0);
    prog[rel_target+1]  = encode_inst(e_op_send, 0, 0, int'(e_cmd_ack));
    prog[rel_target+2]  = encode_inst(e_op_bi, 0, 0, 0);
  endtask

  task automatic load_ucode();
    for (int a = 0; a < ucode_depth; a++) begin
      cfg_w_v  = 1'b1;
      cfg_addr = pc_width'(a);
      cfg_data = prog[a];
      @(posedge clk);
      #1;
    end
    cfg_w_v = 1'b0;
  endtask

  task automatic read_ucode();
    for (int a = 0; a < ucode_depth; a++) begin
      cfg_r_v  = 1'b1;
      cfg_addr = pc_width'(a);
      @(posedge clk);
      #1;
    end
    cfg_r_v = 1'b0;
    @(posedge clk);
    #1;
  endtask

  ////////////////////////////////////////
  // LCE traffic
  ////////////////////////////////////////

  // Way groups 0 to 3 only, so requests collide on pending bits
  task automatic drive_request();
    logic [31:0] rnd;
    logic [1:0]  kind;
    rnd      = $random(seed);
    kind     = rnd[1:0];
    req_v    = 1'b1;
    req_lce  = rnd[3:2];
    req_addr = {rnd[15:10], 2'b00, rnd[5:4], rnd[21:16]};
    if (kind == 2'd3) begin
      kind = 2'd1;
    end
    req_type = lce_req_type_e'(kind);
  endtask

  task automatic run_traffic();
    logic [31:0] rnd;
    logic        taken;
    int          issued;
    int          idle_left;
    issued    = 0;
    idle_left = 2;
    while (cmd_count < num_reqs) begin
      @(negedge clk);
      taken = req_v & req_yumi;
      @(posedge clk);
      #1;
      rnd       = $random(seed);
      // Ready drops about one cycle in four
      cmd_ready = (rnd[1:0] != 2'b00);
      if (taken) begin
        req_v     = 1'b0;
        issued    = issued + 1;
        idle_left = int'(rnd[3:2]);
      end else if (!req_v && issued < num_reqs) begin
        if (idle_left == 0) begin
          drive_request();
        end else begin
          idle_left = idle_left - 1;
        end
      end
    end
  endtask

  initial begin
    seed      = 37459;
    rst       = 1'b1;
    cfg_w_v   = 1'b0;
    cfg_r_v   = 1'b0;
    cfg_run   = 1'b0;
    cfg_addr  = '0;
    cfg_data  = '0;
    req_v     = 1'b0;
    req_lce   = '0;
    req_addr  = '0;
    req_type  = e_req_rd;
    cmd_ready = 1'b0;
    done      = 1'b0;
    build_program();
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;
    // First request already waits while the engine stays halted
    drive_request();
    repeat (4) @(posedge clk);
    #1;
    load_ucode();
    read_ucode();
    cfg_run = 1'b1;
    run_traffic();
    repeat (2) @(posedge clk);
    done = 1'b1;
    #1;
    if (error_count == 0 && cmd_count == num_reqs) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  initial begin
    while (cycle_count < timeout_cycles) begin
      @(posedge clk);
    end
    $display("Timeout after %0d cycles with %0d of %0d commands checked and %0d errors",
             cycle_count, cmd_count, num_reqs, error_count);
    $display("Something failed");
    $finish;
  end

endmodule

// File: tests/cce_checker.sv
// CCE checker that models the coherence rule and compares config readback and LCE commands

`timescale 1ns/1ps

module cce_checker import cce_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    cfg_w_v_i,
  input  logic                    cfg_r_v_i,
  input  logic                    cfg_run_i,
  input  logic [pc_width-1:0]     cfg_addr_i,
  input  logic [inst_width-1:0]   cfg_data_i,
  input  logic [inst_width-1:0]   cfg_ucode_data_i,
  input  logic                    lce_req_v_i,
  input  logic [lce_id_width-1:0] lce_req_lce_i,
  input  logic [paddr_width-1:0]  lce_req_addr_i,
  input  lce_req_type_e           lce_req_type_i,
  input  logic                    lce_req_yumi_i,
  input  logic                    lce_cmd_v_i,
  input  logic [lce_id_width-1:0] lce_cmd_lce_i,
  input  logic [paddr_width-1:0]  lce_cmd_addr_i,
  input  lce_cmd_type_e           lce_cmd_type_i,
  input  logic [gpr_width-1:0]    lce_cmd_data_i,
  input  logic                    lce_cmd_ready_i,
  input  logic                    done_i,
  output int                      error_count_o,
  output int                      cmd_count_o
);

  typedef struct packed {
    lce_cmd_type_e           cmd_type;
    logic [gpr_width-1:0]    data;
    logic [lce_id_width-1:0] lce;
    logic [paddr_width-1:0]  addr;
  } cmd_t;

  cmd_t                      expect_q[$];
  cmd_t                      held_cmd;
  logic                      held_v;
  logic [inst_width-1:0]     ucode_model [ucode_depth];
  logic [num_way_groups-1:0] pend_model;
  logic [gpr_width-1:0]      grants;
  logic                      rd_v;
  logic [pc_width-1:0]       rd_addr;
  int                        rd_count;

  // Release frees the way group, a pending group retries, anything else is a grant
  function automatic lce_cmd_type_e predict_cmd(
    input  lce_req_type_e        req_type,
    input  logic                 pend,
    input  logic [gpr_width-1:0] grants_in,
    output logic                 pend_next,
    output logic [gpr_width-1:0] grants_next
  );
    pend_next   = pend;
    grants_next = grants_in;
    if (req_type == e_req_rel) begin
      pend_next = 1'b0;
      return e_cmd_ack;
    end
    if (pend) begin
      return e_cmd_retry;
    end
    grants_next = grants_in + gpr_width'(1);
    if (req_type == e_req_wr) begin
      pend_next = 1'b1;
      return e_cmd_grant_e;
    end
    return e_cmd_grant_s;
  endfunction

  task automatic check_field(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      error_count_o++;
      $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic compare_cmd(input cmd_t got, input cmd_t exp);
    check_field("lce_cmd_type_o", 32'(got.cmd_type), 32'(exp.cmd_type));
    check_field("lce_cmd_data_o", 32'(got.data), 32'(exp.data));
    check_field("lce_cmd_lce_o", 32'(got.lce), 32'(exp.lce));
    check_field("lce_cmd_addr_o", 32'(got.addr), 32'(exp.addr));
  endtask

  ////////////////////////////////////////
  // Sampling at the falling edge
  ////////////////////////////////////////

  always @(negedge clk_i) begin
    cmd_t                         got;
    cmd_t                         exp;
    logic [lg_num_way_groups-1:0] wg;
    logic                         pend_next;
    logic [gpr_width-1:0]         grants_next;
    got.cmd_type = lce_cmd_type_i;
    got.data     = lce_cmd_data_i;
    got.lce      = lce_cmd_lce_i;
    got.addr     = lce_cmd_addr_i;
    if (rst_i) begin
      expect_q.delete();
      pend_model    = '0;
      grants        = '0;
      rd_v          = 1'b0;
      held_v        = 1'b0;
      rd_count      = 0;
      error_count_o = 0;
      cmd_count_o   = 0;
    end else begin
      // Readback shows up one cycle after the read
      if (rd_v) begin
        check_field("cfg_ucode_data_o", cfg_ucode_data_i, ucode_model[rd_addr]);
        rd_count++;
      end
      rd_v    = cfg_r_v_i & ~cfg_run_i;
      rd_addr = cfg_addr_i;
      if (cfg_w_v_i) begin
        ucode_model[cfg_addr_i] = cfg_data_i;
      end
      if (!cfg_run_i && (lce_cmd_v_i || lce_req_yumi_i)) begin
        error_count_o++;
        $display("** Error: lce_cmd_v_o = 0x%0h, lce_req_yumi_o = 0x%0h while halted, expected 0x0",
                 lce_cmd_v_i, lce_req_yumi_i);
      end
      // A waiting command holds every field
      if (held_v) begin
        check_field("lce_cmd_v_o", 32'(lce_cmd_v_i), 32'd1);
        compare_cmd(got, held_cmd);
      end
      held_v   = lce_cmd_v_i & ~lce_cmd_ready_i;
      held_cmd = got;
      if (lce_cmd_v_i && lce_cmd_ready_i) begin
        if (expect_q.size() == 0) begin
          error_count_o++;
          $display("A command was sent with no accepted request left to answer");
        end else begin
          exp = expect_q.pop_front();
          compare_cmd(got, exp);
          cmd_count_o++;
        end
      end
      if (lce_req_yumi_i && !lce_req_v_i) begin
        error_count_o++;
        $display("** Error: lce_req_yumi_o = 0x1 while lce_req_v_i = 0x0");
      end else if (lce_req_yumi_i) begin
        wg = lce_req_addr_i[block_offset_width +: lg_num_way_groups];
        exp.cmd_type = predict_cmd(lce_req_type_i, pend_model[wg], grants, pend_next,
                                   grants_next);
        exp.data     = grants_next;
        exp.lce      = lce_req_lce_i;
        exp.addr     = lce_req_addr_i;
        pend_model[wg] = pend_next;
        grants         = grants_next;
        expect_q.push_back(exp);
      end
    end
  end

  always @(posedge done_i) begin
    $display("Checker summary: %0d commands, %0d readbacks, %0d errors",
             cmd_count_o, rd_count, error_count_o);
  end

endmodule

// File: source/cce.sv
// CCE top level joining fetch, decode, execute, pending table and message unit

`timescale 1ns/1ps

module cce import cce_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    cfg_w_v_i,
  input  logic                    cfg_r_v_i,
  input  logic                    cfg_run_i,
  input  logic [pc_width-1:0]     cfg_addr_i,
  input  logic [inst_width-1:0]   cfg_data_i,
  output logic [inst_width-1:0]   cfg_ucode_data_o,
  input  logic                    lce_req_v_i,
  input  logic [lce_id_width-1:0] lce_req_lce_i,
  input  logic [paddr_width-1:0]  lce_req_addr_i,
  input  lce_req_type_e           lce_req_type_i,
  output logic                    lce_req_yumi_o,
  output logic                    lce_cmd_v_o,
  output logic [lce_id_width-1:0] lce_cmd_lce_o,
  output logic [paddr_width-1:0]  lce_cmd_addr_o,
  output lce_cmd_type_e           lce_cmd_type_o,
  output logic [gpr_width-1:0]    lce_cmd_data_o,
  input  logic                    lce_cmd_ready_i
);

  // Fetch to decode
  logic [inst_width-1:0]    fetch_inst;
  logic                     fetch_inst_v;
  // Decode to execute and message unit
  cce_opcode_e              ex_op;
  logic [gpr_sel_width-1:0] ex_dst;
  logic [gpr_sel_width-1:0] ex_src_a;
  logic [gpr_sel_width-1:0] ex_src_b;
  logic [imm_width-1:0]     ex_imm;
  logic                     ex_inst_v;
  logic                     stall;
  // Branch resolution
  logic                     redirect;
  logic [pc_width-1:0]      redirect_pc;
  // Message unit and pending table
  logic                     req_wait;
  logic                     cmd_busy;
  logic [paddr_width-1:0]   mshr_addr;
  logic [num_flags-1:0]     mshr_flags;
  logic                     pending;
  logic                     pending_w_v;
  logic [gpr_width-1:0]     send_data;

  cce_inst_ram u_inst_ram (
    .clk_i(clk_i), .rst_i(rst_i),
    .cfg_w_v_i(cfg_w_v_i), .cfg_r_v_i(cfg_r_v_i), .cfg_run_i(cfg_run_i),
    .cfg_addr_i(cfg_addr_i), .cfg_data_i(cfg_data_i),
    .stall_i(stall), .redirect_i(redirect), .redirect_pc_i(redirect_pc),
    .cfg_ucode_data_o(cfg_ucode_data_o), .inst_o(fetch_inst), .inst_v_o(fetch_inst_v)
  );

  cce_inst_decode u_inst_decode (
    .clk_i(clk_i), .rst_i(rst_i),
    .inst_i(fetch_inst), .inst_v_i(fetch_inst_v), .redirect_i(redirect),
    .req_wait_i(req_wait), .cmd_busy_i(cmd_busy),
    .op_o(ex_op), .dst_o(ex_dst), .src_a_o(ex_src_a), .src_b_o(ex_src_b),
    .imm_o(ex_imm), .inst_v_o(ex_inst_v), .stall_o(stall)
  );

  cce_execute u_execute (
    .clk_i(clk_i), .rst_i(rst_i),
    .op_i(ex_op), .dst_i(ex_dst), .src_a_i(ex_src_a), .src_b_i(ex_src_b),
    .imm_i(ex_imm), .inst_v_i(ex_inst_v), .stall_i(stall), .mshr_flags_i(mshr_flags),
    .redirect_o(redirect), .redirect_pc_o(redirect_pc), .send_data_o(send_data)
  );

  // Wdp writes immediate bit 0
  cce_pending u_pending (
    .clk_i(clk_i), .rst_i(rst_i),
    .w_v_i(pending_w_v), .addr_i(mshr_addr), .pending_i(ex_imm[0]),
    .pending_o(pending)
  );

  cce_msg u_msg (
    .clk_i(clk_i), .rst_i(rst_i),
    .op_i(ex_op), .imm_i(ex_imm), .inst_v_i(ex_inst_v), .stall_i(stall),
    .pending_i(pending), .send_data_i(send_data),
    .lce_req_v_i(lce_req_v_i), .lce_req_lce_i(lce_req_lce_i),
    .lce_req_addr_i(lce_req_addr_i), .lce_req_type_i(lce_req_type_i),
    .lce_req_yumi_o(lce_req_yumi_o),
    .mshr_addr_o(mshr_addr), .mshr_flags_o(mshr_flags),
    .req_wait_o(req_wait), .cmd_busy_o(cmd_busy), .pending_w_v_o(pending_w_v),
    .lce_cmd_v_o(lce_cmd_v_o), .lce_cmd_lce_o(lce_cmd_lce_o),
    .lce_cmd_addr_o(lce_cmd_addr_o), .lce_cmd_type_o(lce_cmd_type_o),
    .lce_cmd_data_o(lce_cmd_data_o), .lce_cmd_ready_i(lce_cmd_ready_i)
  );

endmodule

// File: source/cce_msg.sv
// CCE message unit with request intake into the MSHR and the LCE command register

`timescale 1ns/1ps

module cce_msg import cce_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  cce_opcode_e             op_i,
  input  logic [imm_width-1:0]    imm_i,
  input  logic                    inst_v_i,
  input  logic                    stall_i,
  input  logic                    pending_i,
  input  logic [gpr_width-1:0]    send_data_i,
  input  logic                    lce_req_v_i,
  input  logic [lce_id_width-1:0] lce_req_lce_i,
  input  logic [paddr_width-1:0]  lce_req_addr_i,
  input  lce_req_type_e           lce_req_type_i,
  output logic                    lce_req_yumi_o,
  output logic [paddr_width-1:0]  mshr_addr_o,
  output logic [num_flags-1:0]    mshr_flags_o,
  output logic                    req_wait_o,
  output logic                    cmd_busy_o,
  output logic                    pending_w_v_o,
  output logic                    lce_cmd_v_o,
  output logic [lce_id_width-1:0] lce_cmd_lce_o,
  output logic [paddr_width-1:0]  lce_cmd_addr_o,
  output lce_cmd_type_e           lce_cmd_type_o,
  output logic [gpr_width-1:0]    lce_cmd_data_o,
  input  logic                    lce_cmd_ready_i
);

  logic [lce_id_width-1:0] mshr_lce_q;
  logic [paddr_width-1:0]  mshr_addr_q;
  logic [num_flags-1:0]    mshr_flags_q;
  logic                    fire;
  logic                    send_v;

  assign fire   = inst_v_i & ~stall_i;
  assign send_v = fire & (op_i == e_op_send);

  ////////////////////////////////////////
  // Request intake and MSHR
  ////////////////////////////////////////

  assign lce_req_yumi_o = fire & (op_i == e_op_poph) & lce_req_v_i;
  assign req_wait_o     = ~lce_req_v_i;
  assign pending_w_v_o  = fire & (op_i == e_op_wdp);

  always_ff @(posedge clk_i) begin
    if (lce_req_yumi_o) begin
      mshr_lce_q  <= lce_req_lce_i;
      mshr_addr_q <= lce_req_addr_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mshr_flags_q <= '0;
    end else if (lce_req_yumi_o) begin
      mshr_flags_q              <= '0;
      mshr_flags_q[e_flag_wr]   <= (lce_req_type_i == e_req_wr);
      mshr_flags_q[e_flag_rel]  <= (lce_req_type_i == e_req_rel);
    end else if (fire & (op_i == e_op_rdp)) begin
      mshr_flags_q[e_flag_pend] <= pending_i;
    end
  end

  assign mshr_addr_o  = mshr_addr_q;
  assign mshr_flags_o = mshr_flags_q;

  ////////////////////////////////////////
  // Command output register
  ////////////////////////////////////////

  // No room while a command waits for ready
  assign cmd_busy_o = lce_cmd_v_o & ~lce_cmd_ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      lce_cmd_v_o <= 1'b0;
    end else if (send_v) begin
      lce_cmd_v_o <= 1'b1;
    end else if (lce_cmd_ready_i) begin
      lce_cmd_v_o <= 1'b0;
    end
  end

  // Command type from the low immediate bits
  always_ff @(posedge clk_i) begin
    if (send_v) begin
      lce_cmd_lce_o  <= mshr_lce_q;
      lce_cmd_addr_o <= mshr_addr_q;
      lce_cmd_type_o <= lce_cmd_type_e'(imm_i[1:0]);
      lce_cmd_data_o <= send_data_i;
    end
  end

  a_cmd_stable: assert property (
    @(posedge clk_i) disable iff (rst_i)
    lce_cmd_v_o && !lce_cmd_ready_i |=> lce_cmd_v_o &&
      $stable({lce_cmd_lce_o, lce_cmd_addr_o, lce_cmd_type_o, lce_cmd_data_o})
  );

endmodule

// File: source/cce_pending.sv
// CCE pending-bit table holding one bit per way group

`timescale 1ns/1ps

module cce_pending import cce_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   w_v_i,
  input  logic [paddr_width-1:0] addr_i,
  input  logic                   pending_i,
  output logic                   pending_o
);

  logic [num_way_groups-1:0]    pending_q;
  logic [lg_num_way_groups-1:0] way_group;

  // Way group bits sit right above the block offset
  assign way_group = addr_i[block_offset_width +: lg_num_way_groups];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pending_q <= '0;
    end else if (w_v_i) begin
      pending_q[way_group] <= pending_i;
    end
  end

  // Read is combinational from the MSHR address
  assign pending_o = pending_q[way_group];

endmodule

// File: source/cce_execute.sv
// CCE execute stage with register file, ALU and branch resolution

`timescale 1ns/1ps

module cce_execute import cce_pkg::*; (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  cce_opcode_e              op_i,
  input  logic [gpr_sel_width-1:0] dst_i,
  input  logic [gpr_sel_width-1:0] src_a_i,
  input  logic [gpr_sel_width-1:0] src_b_i,
  input  logic [imm_width-1:0]     imm_i,
  input  logic                     inst_v_i,
  input  logic                     stall_i,
  input  logic [num_flags-1:0]     mshr_flags_i,
  output logic                     redirect_o,
  output logic [pc_width-1:0]      redirect_pc_o,
  output logic [gpr_width-1:0]     send_data_o
);

  logic [gpr_width-1:0] gpr [num_gpr];
  logic [gpr_width-1:0] opd_a;
  logic [gpr_width-1:0] opd_b;
  logic [gpr_width-1:0] alu_res;
  logic                 gpr_w_v;
  logic                 taken;
  logic                 fire;
  logic [num_flags-1:0] flag_mask;
  logic [num_flags-1:0] masked_flags;

  assign fire  = inst_v_i & ~stall_i;
  assign opd_a = gpr[src_a_i];
  assign opd_b = gpr[src_b_i];

  // Flag mask comes from the low immediate bits
  assign flag_mask    = imm_i[num_flags-1:0];
  assign masked_flags = mshr_flags_i & flag_mask;

  ////////////////////////////////////////
  // ALU and branch unit
  ////////////////////////////////////////

  always_comb begin
    alu_res = opd_a;
    gpr_w_v = 1'b0;
    taken   = 1'b0;
    case (op_i)
      e_op_add: begin
        alu_res = opd_a + opd_b;
        gpr_w_v = 1'b1;
      end
      e_op_sub: begin
        alu_res = opd_a - opd_b;
        gpr_w_v = 1'b1;
      end
      e_op_addi: begin
        alu_res = opd_a + imm_i;
        gpr_w_v = 1'b1;
      end
      e_op_movi: begin
        alu_res = imm_i;
        gpr_w_v = 1'b1;
      end
      e_op_beq:   taken = (opd_a == opd_b);
      e_op_bne:   taken = (opd_a != opd_b);
      e_op_bi:    taken = 1'b1;
      // All masked flags set
      e_op_bfand: taken = (masked_flags == flag_mask);
      // Any masked flag set
      e_op_bfor:  taken = |masked_flags;
      default: begin
        gpr_w_v = 1'b0;
        taken   = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < num_gpr; i++) begin
        gpr[i] <= '0;
      end
    end else if (fire & gpr_w_v) begin
      gpr[dst_i] <= alu_res;
    end
  end

  assign redirect_o    = fire & taken;
  assign redirect_pc_o = imm_i[pc_width-1:0];
  assign send_data_o   = opd_a;

endmodule

// File: source/cce_inst_decode.sv
// CCE decode stage register with field split, stall detection and squash

`timescale 1ns/1ps

module cce_inst_decode import cce_pkg::*; (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic [inst_width-1:0]    inst_i,
  input  logic                     inst_v_i,
  input  logic                     redirect_i,
  input  logic                     req_wait_i,
  input  logic                     cmd_busy_i,
  output cce_opcode_e              op_o,
  output logic [gpr_sel_width-1:0] dst_o,
  output logic [gpr_sel_width-1:0] src_a_o,
  output logic [gpr_sel_width-1:0] src_b_o,
  output logic [imm_width-1:0]     imm_o,
  output logic                     inst_v_o,
  output logic                     stall_o
);

  logic [inst_width-1:0] inst_q;
  logic                  inst_v_q;
  logic                  poph_wait;
  logic                  send_wait;

  ////////////////////////////////////////
  // Execute stage register
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      inst_v_q <= 1'b0;
    end else if (redirect_i) begin
      // Squash the instruction behind a taken branch
      inst_v_q <= 1'b0;
    end else if (!stall_o) begin
      inst_v_q <= inst_v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!stall_o) begin
      inst_q <= inst_i;
    end
  end

  ////////////////////////////////////////
  // Field split
  ////////////////////////////////////////

  assign op_o     = cce_opcode_e'(inst_q[op_lsb +: op_width]);
  assign dst_o    = inst_q[dst_lsb +: gpr_sel_width];
  assign src_a_o  = inst_q[src_a_lsb +: gpr_sel_width];
  assign src_b_o  = inst_q[src_b_lsb +: gpr_sel_width];
  assign imm_o    = inst_q[imm_lsb +: imm_width];
  assign inst_v_o = inst_v_q;

  // Poph needs a request, send needs a free command slot
  assign poph_wait = (op_o == e_op_poph) & req_wait_i;
  assign send_wait = (op_o == e_op_send) & cmd_busy_i;
  assign stall_o   = inst_v_q & (poph_wait | send_wait);

endmodule

// File: source/cce_inst_ram.sv
// CCE microcode RAM with configuration access and the fetch program counter

`timescale 1ns/1ps

module cce_inst_ram import cce_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  cfg_w_v_i,
  input  logic                  cfg_r_v_i,
  input  logic                  cfg_run_i,
  input  logic [pc_width-1:0]   cfg_addr_i,
  input  logic [inst_width-1:0] cfg_data_i,
  input  logic                  stall_i,
  input  logic                  redirect_i,
  input  logic [pc_width-1:0]   redirect_pc_i,
  output logic [inst_width-1:0] cfg_ucode_data_o,
  output logic [inst_width-1:0] inst_o,
  output logic                  inst_v_o
);

  logic [inst_width-1:0] mem [ucode_depth];
  logic [inst_width-1:0] inst_q;
  logic [pc_width-1:0]   pc_q;
  logic                  inst_v_q;
  logic                  fetch_en;

  assign fetch_en = cfg_run_i & ~stall_i & ~redirect_i;

  always_ff @(posedge clk_i) begin
    if (cfg_w_v_i) begin
      mem[cfg_addr_i] <= cfg_data_i;
    end
  end

  // Readback shares the fetch read port while halted
  always_ff @(posedge clk_i) begin
    if (cfg_r_v_i & ~cfg_run_i) begin
      inst_q <= mem[cfg_addr_i];
    end else if (fetch_en) begin
      inst_q <= mem[pc_q];
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i | ~cfg_run_i) begin
      pc_q     <= '0;
      inst_v_q <= 1'b0;
    end else if (redirect_i) begin
      // Restart at the target, wrong-path word is dropped
      pc_q     <= redirect_pc_i;
      inst_v_q <= 1'b0;
    end else if (!stall_i) begin
      pc_q     <= pc_q + 1'b1;
      inst_v_q <= 1'b1;
    end
  end

  assign inst_o           = inst_q;
  assign inst_v_o         = inst_v_q;
  assign cfg_ucode_data_o = inst_q;

  // Microcode only changes while the engine is halted
  a_no_write_while_run: assert property (
    @(posedge clk_i) disable iff (rst_i) cfg_w_v_i |-> !cfg_run_i
  );

endmodule

// File: source/cce_pkg.sv
// CCE package with widths, instruction fields and shared encodings

package cce_pkg;

  ////////////////////////////////////////
  // Address and way groups
  ////////////////////////////////////////

  localparam int paddr_width        = 16;
  localparam int block_offset_width = 6;
  localparam int num_way_groups     = 16;
  // Way group index sits just above the block offset
  localparam int lg_num_way_groups  = 4;
  localparam int lce_id_width       = 2;

  ////////////////////////////////////////
  // Registers and microcode
  ////////////////////////////////////////

  localparam int gpr_width     = 16;
  localparam int num_gpr       = 4;
  localparam int gpr_sel_width = 2;
  localparam int inst_width    = 32;
  localparam int imm_width     = 16;
  localparam int ucode_depth   = 64;
  localparam int pc_width      = 6;
  localparam int op_width      = 5;
  localparam int num_flags     = 3;

  // Field positions, high to low: opcode, dst, src_a, src_b, spare, imm
  localparam int op_lsb    = 27;
  localparam int dst_lsb   = 25;
  localparam int src_a_lsb = 23;
  localparam int src_b_lsb = 21;
  localparam int imm_lsb   = 0;

  typedef enum logic [op_width-1:0] {
    e_op_add   = 5'd0,
    e_op_sub   = 5'd1,
    e_op_addi  = 5'd2,
    e_op_movi  = 5'd3,
    e_op_beq   = 5'd4,
    e_op_bne   = 5'd5,
    e_op_bi    = 5'd6,
    e_op_bfand = 5'd7,
    e_op_bfor  = 5'd8,
    e_op_poph  = 5'd9,
    e_op_rdp   = 5'd10,
    e_op_wdp   = 5'd11,
    e_op_send  = 5'd12,
    e_op_nop   = 5'd31
  } cce_opcode_e;

  typedef enum logic [1:0] {
    e_req_rd  = 2'd0,
    e_req_wr  = 2'd1,
    e_req_rel = 2'd2
  } lce_req_type_e;

  typedef enum logic [1:0] {
    e_cmd_grant_s = 2'd0,
    e_cmd_grant_e = 2'd1,
    e_cmd_retry   = 2'd2,
    e_cmd_ack     = 2'd3
  } lce_cmd_type_e;

  // Bit positions in the MSHR flag vector
  typedef enum int {
    e_flag_wr   = 0,
    e_flag_rel  = 1,
    e_flag_pend = 2
  } mshr_flag_e;

endpackage
